// ==== design/alu_pkg.sv ====
// ####################################################################
// operation, condition and command word definitions for the lanes
// shared by dispatch, exec lanes and the testbench model
// ####################################################################
package alu_pkg;

  localparam int DATA_W  = 32;
  localparam int MUL_LAT = 4;  // issue edge to done edge
  localparam int ALU_LAT = 2;

  // flag bit positions in the 4-bit flags word
  localparam int FLAG_C = 3;
  localparam int FLAG_V = 2;
  localparam int FLAG_N = 1;
  localparam int FLAG_Z = 0;

  // sxt_mode encodings
  localparam logic [1:0] SXT_BYTE = 2'd0;
  localparam logic [1:0] SXT_HALF = 2'd1;
  localparam logic [1:0] SXT_SWAP = 2'd2;
  localparam logic [1:0] SXT_PASS = 2'd3;

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_ADC   = 4'd2,
    OP_AND   = 4'd3,
    OP_OR    = 4'd4,
    OP_XOR   = 4'd5,
    OP_SLL   = 4'd6,
    OP_SRL   = 4'd7,
    OP_SRA   = 4'd8,
    OP_SXT   = 4'd9,
    OP_MOVI  = 4'd10,
    OP_MUL   = 4'd11,
    OP_MULHU = 4'd12
  } op_e;

  typedef enum logic [3:0] {
    COND_Z      = 4'd0,
    COND_NZ     = 4'd1,
    COND_C      = 4'd2,
    COND_NC     = 4'd3,
    COND_N      = 4'd4,
    COND_NN     = 4'd5,
    COND_V      = 4'd6,
    COND_NV     = 4'd7,
    COND_HI     = 4'd8,   // c and not z
    COND_LS     = 4'd9,
    COND_GE     = 4'd10,
    COND_LT     = 4'd11,
    COND_GT     = 4'd12,
    COND_LE     = 4'd13,
    COND_ALWAYS = 4'd14,
    COND_NEVER  = 4'd15
  } cond_e;

  typedef struct packed {
    logic signed [15:0] imm;
  } imm_view_t;

  typedef struct packed {
    logic [13:0] unused;
    logic [1:0]  sxt_mode;
  } ext_view_t;

  // same 16 payload bits, decoded per op
  typedef union packed {
    imm_view_t imm;
    ext_view_t ext;
  } payload_u;

  typedef struct packed {
    op_e        op;        // 31:28
    cond_e      cond;      // 27:24
    logic [3:0] flags_in;  // 23:20
    logic       use_imm;   // 19
    logic [2:0] spare;     // 18:16
    payload_u   payload;   // 15:0
  } cmd_t;

  function automatic logic cond_pass(cond_e cond, logic [3:0] flags);
    logic c;
    logic v;
    logic n;
    logic z;
    c = flags[FLAG_C];
    v = flags[FLAG_V];
    n = flags[FLAG_N];
    z = flags[FLAG_Z];
    case (cond)
      COND_Z:      cond_pass = z;
      COND_NZ:     cond_pass = !z;
      COND_C:      cond_pass = c;
      COND_NC:     cond_pass = !c;
      COND_N:      cond_pass = n;
      COND_NN:     cond_pass = !n;
      COND_V:      cond_pass = v;
      COND_NV:     cond_pass = !v;
      COND_HI:     cond_pass = c && !z;
      COND_LS:     cond_pass = !c || z;
      COND_GE:     cond_pass = n == v;
      COND_LT:     cond_pass = n != v;
      COND_GT:     cond_pass = !z && (n == v);
      COND_LE:     cond_pass = z || (n != v);
      COND_ALWAYS: cond_pass = 1'b1;
      default:     cond_pass = 1'b0;
    endcase
  endfunction

endpackage

// ==== design/bus_pkg.sv ====
// ####################################################################
// Wishbone register map and status word layout of the cluster
// ####################################################################
package bus_pkg;

  localparam int BUS_W = 32;
  localparam int ADR_W = 3;

  localparam logic [ADR_W-1:0] ADR_OPA    = 3'd0;
  localparam logic [ADR_W-1:0] ADR_OPB    = 3'd1;
  localparam logic [ADR_W-1:0] ADR_CMD    = 3'd2;  // write launches the op
  localparam logic [ADR_W-1:0] ADR_RESULT = 3'd3;
  localparam logic [ADR_W-1:0] ADR_STATUS = 3'd4;  // read pops when valid

  // status word bit positions
  localparam int ST_VALID    = 0;
  localparam int ST_TAKEN    = 1;
  localparam int ST_FLAGS_LO = 2;  // flags in 5:2
  localparam int ST_TAG_LO   = 6;

endpackage

// ==== design/op_dispatch.sv ====
// ####################################################################
// Wishbone classic slave in front of the lanes: stages operands,
// issues commands round-robin with sequential tags, pops results
// ####################################################################
`timescale 1ns/100ps

module op_dispatch #(
  parameter int N_LANES   = 4,
  parameter int ROB_DEPTH = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cyc,
  input  logic                          stb,
  input  logic                          we,
  input  logic [bus_pkg::ADR_W-1:0]     adr,
  input  logic [bus_pkg::BUS_W-1:0]     dat_w,
  output logic [bus_pkg::BUS_W-1:0]     dat_r,
  output logic                          ack,
  output logic [N_LANES-1:0]            issue,
  output alu_pkg::cmd_t                 cmd,
  output logic [bus_pkg::BUS_W-1:0]     opa,
  output logic [bus_pkg::BUS_W-1:0]     opb,
  output logic [$clog2(ROB_DEPTH)-1:0]  tag,
  input  logic [N_LANES-1:0]            lane_busy,
  output logic                          pop,
  input  logic                          head_valid,
  input  logic [bus_pkg::BUS_W-1:0]     head_result,
  input  logic [bus_pkg::BUS_W-1:0]     head_status
);

  localparam int TAG_W = $clog2(ROB_DEPTH);
  localparam int PTR_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

  logic             req;
  logic             is_cmd;
  logic             cmd_ready;
  logic             accept;
  logic [PTR_W-1:0] lane_ptr;
  logic [TAG_W:0]   outstanding;

  assign req       = cyc && stb && !ack;
  assign is_cmd    = we && (adr == bus_pkg::ADR_CMD);
  // hold off CMD ack while target lane busy or reorder slots all taken
  assign cmd_ready = !lane_busy[lane_ptr] && (outstanding < (TAG_W+1)'(ROB_DEPTH));
  assign accept    = req && (!is_cmd || cmd_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      ack         <= 1'b0;
      issue       <= '0;
      pop         <= 1'b0;
      lane_ptr    <= '0;
      tag         <= '0;
      outstanding <= '0;
    end else begin
      ack   <= accept;
      issue <= (accept && is_cmd) ? N_LANES'(1) << lane_ptr : '0;
      pop   <= accept && !we && (adr == bus_pkg::ADR_STATUS) && head_valid;
      if (|issue) begin  // lane samples tag with this strobe
        tag      <= tag + 1'b1;
        lane_ptr <= (lane_ptr == PTR_W'(N_LANES - 1)) ? '0 : lane_ptr + 1'b1;
      end
      case ({|issue, pop})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  // staging registers and read data
  always_ff @(posedge clk) begin
    if (accept && we) begin
      case (adr)
        bus_pkg::ADR_OPA: opa <= dat_w;
        bus_pkg::ADR_OPB: opb <= dat_w;
        bus_pkg::ADR_CMD: cmd <= alu_pkg::cmd_t'(dat_w);
        default: ;
      endcase
    end
    if (accept && !we) begin
      case (adr)
        bus_pkg::ADR_RESULT: dat_r <= head_result;
        bus_pkg::ADR_STATUS: dat_r <= head_status;
        default:             dat_r <= '0;
      endcase
    end
  end

endmodule

// ==== design/exec_lane.sv ====
// ####################################################################
// one execution lane: condition check, ALU ops in ALU_LAT cycles,
// multiply in MUL_LAT cycles with busy held while it is in flight
// ####################################################################
`timescale 1ns/100ps

module exec_lane #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          issue,
  input  alu_pkg::cmd_t                 cmd,
  input  logic [alu_pkg::DATA_W-1:0]    opa,
  input  logic [alu_pkg::DATA_W-1:0]    opb,
  input  logic [$clog2(ROB_DEPTH)-1:0]  tag,
  output logic                          busy,
  output logic                          done,
  output logic [alu_pkg::DATA_W-1:0]    result,
  output logic [3:0]                    flags_out,
  output logic                          cond_taken,
  output logic [$clog2(ROB_DEPTH)-1:0]  tag_out
);

  localparam int TAG_W = $clog2(ROB_DEPTH);
  localparam int DW    = alu_pkg::DATA_W;
  localparam int PW    = TAG_W + 1 + 4 + DW;  // {tag, taken, flags, result}
  localparam int AD    = alu_pkg::ALU_LAT - 1;
  localparam int MD    = alu_pkg::MUL_LAT - 1;

  logic [DW-1:0]    opb_res;
  logic             is_mul;
  logic             s0_v;
  logic             s0_mul;
  logic             s0_taken;
  alu_pkg::op_e     s0_op;
  logic [1:0]       s0_sxt;
  logic [3:0]       s0_flags;
  logic [DW-1:0]    s0_a;
  logic [DW-1:0]    s0_b;
  logic [TAG_W-1:0] s0_tag;
  logic [DW-1:0]    b_add;
  logic             cin_add;
  logic [DW:0]      sum;
  logic [2*DW-1:0]  prod;
  logic [DW-1:0]    raw;
  logic             c_raw;
  logic             v_raw;
  logic [3:0]       flags_new;
  logic [PW-1:0]    exe_word;
  logic [AD-1:0]    alu_v;
  logic [PW-1:0]    alu_d [AD];
  logic [MD-1:0]    mul_v;
  logic [PW-1:0]    mul_d [MD];

  assign opb_res = cmd.use_imm ?
                   {{(DW-16){cmd.payload.imm.imm[15]}}, cmd.payload.imm.imm} : opb;
  assign is_mul  = (cmd.op == alu_pkg::OP_MUL) || (cmd.op == alu_pkg::OP_MULHU);

  always_ff @(posedge clk) begin
    if (rst) s0_v <= 1'b0;
    else     s0_v <= issue;
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      s0_mul   <= is_mul;
      s0_op    <= cmd.op;
      s0_taken <= alu_pkg::cond_pass(cmd.cond, cmd.flags_in);
      s0_flags <= cmd.flags_in;
      s0_sxt   <= cmd.payload.ext.sxt_mode;  // only meaningful for SXT
      s0_a     <= opa;
      s0_b     <= opb_res;
      s0_tag   <= tag;
    end
  end

  always_comb begin
    b_add   = (s0_op == alu_pkg::OP_SUB) ? ~s0_b : s0_b;
    cin_add = (s0_op == alu_pkg::OP_SUB) ||
              ((s0_op == alu_pkg::OP_ADC) && s0_flags[alu_pkg::FLAG_C]);
    sum     = {1'b0, s0_a} + {1'b0, b_add} + (DW+1)'(cin_add);
    prod    = s0_a * s0_b;
    c_raw   = 1'b0;
    v_raw   = 1'b0;
    case (s0_op)
      alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_ADC: begin
        raw   = sum[DW-1:0];
        c_raw = sum[DW];  // sub: set when no borrow
        v_raw = (s0_a[DW-1] == b_add[DW-1]) && (raw[DW-1] != s0_a[DW-1]);
      end
      alu_pkg::OP_AND:   raw = s0_a & s0_b;
      alu_pkg::OP_OR:    raw = s0_a | s0_b;
      alu_pkg::OP_XOR:   raw = s0_a ^ s0_b;
      alu_pkg::OP_SLL:   raw = s0_a << s0_b[4:0];
      alu_pkg::OP_SRL:   raw = s0_a >> s0_b[4:0];
      alu_pkg::OP_SRA:   raw = $signed(s0_a) >>> s0_b[4:0];
      alu_pkg::OP_SXT: begin
        case (s0_sxt)
          alu_pkg::SXT_BYTE: raw = {{(DW-8){s0_a[7]}}, s0_a[7:0]};
          alu_pkg::SXT_HALF: raw = {{(DW-16){s0_a[15]}}, s0_a[15:0]};
          alu_pkg::SXT_SWAP: raw = {s0_a[7:0], s0_a[15:8], s0_a[23:16], s0_a[31:24]};
          default:           raw = s0_a;
        endcase
      end
      alu_pkg::OP_MOVI:  raw = s0_b;
      alu_pkg::OP_MUL:   raw = prod[DW-1:0];
      alu_pkg::OP_MULHU: raw = prod[2*DW-1:DW];
      default:           raw = s0_a;
    endcase
    flags_new                 = '0;
    flags_new[alu_pkg::FLAG_C] = c_raw;
    flags_new[alu_pkg::FLAG_V] = v_raw;
    flags_new[alu_pkg::FLAG_N] = raw[DW-1];
    flags_new[alu_pkg::FLAG_Z] = (raw == '0);
    // failed condition passes A and the incoming flags through
    if (s0_taken) exe_word = {s0_tag, 1'b1, flags_new, raw};
    else          exe_word = {s0_tag, 1'b0, s0_flags, s0_a};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_v <= '0;
      mul_v <= '0;
      busy  <= 1'b0;
      done  <= 1'b0;
    end else begin
      alu_v <= AD'({alu_v, s0_v && !s0_mul});
      mul_v <= MD'({mul_v, s0_v && s0_mul});
      done  <= alu_v[AD-1] || mul_v[MD-1];
      if (issue && is_mul)  busy <= 1'b1;
      else if (mul_v[MD-1]) busy <= 1'b0;  // drops with the mul's done
    end
  end

  always_ff @(posedge clk) begin
    alu_d[0] <= exe_word;
    mul_d[0] <= exe_word;
    for (int i = 1; i < AD; i++) alu_d[i] <= alu_d[i-1];
    for (int i = 1; i < MD; i++) mul_d[i] <= mul_d[i-1];
    {tag_out, cond_taken, flags_out, result} <= mul_v[MD-1] ? mul_d[MD-1] : alu_d[AD-1];
  end

endmodule

// ==== design/result_collector.sv ====
// ####################################################################
// reorder slots indexed by tag; lanes write out of order, the head
// slot is presented to the bus in issue order and popped on read
// ####################################################################
`timescale 1ns/100ps

module result_collector #(
  parameter int N_LANES   = 4,
  parameter int ROB_DEPTH = 8
) (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [N_LANES-1:0]                               lane_done,
  input  logic [N_LANES-1:0][bus_pkg::BUS_W-1:0]           lane_result,
  input  logic [N_LANES-1:0][3:0]                          lane_flags,
  input  logic [N_LANES-1:0]                               lane_taken,
  input  logic [N_LANES-1:0][$clog2(ROB_DEPTH)-1:0]        lane_tag,
  input  logic                                             pop,
  output logic                                             head_valid,
  output logic [bus_pkg::BUS_W-1:0]                        head_result,
  output logic [bus_pkg::BUS_W-1:0]                        head_status
);

  localparam int TAG_W = $clog2(ROB_DEPTH);

  logic [ROB_DEPTH-1:0]      slot_v;
  logic [bus_pkg::BUS_W-1:0] slot_res   [ROB_DEPTH];
  logic [3:0]                slot_flags [ROB_DEPTH];
  logic                      slot_taken [ROB_DEPTH];
  logic [TAG_W-1:0]          head;

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_v <= '0;
      head   <= '0;
    end else begin
      if (pop) begin
        slot_v[head] <= 1'b0;
        head         <= head + 1'b1;
      end
      // tags are unique while outstanding, so no write hits the popped slot
      for (int i = 0; i < N_LANES; i++) begin
        if (lane_done[i]) slot_v[lane_tag[i]] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < N_LANES; i++) begin
      if (lane_done[i]) begin
        slot_res[lane_tag[i]]   <= lane_result[i];
        slot_flags[lane_tag[i]] <= lane_flags[i];
        slot_taken[lane_tag[i]] <= lane_taken[i];
      end
    end
  end

  assign head_valid  = slot_v[head];
  assign head_result = slot_res[head];

  always_comb begin
    head_status                                  = '0;
    head_status[bus_pkg::ST_VALID]               = slot_v[head];
    head_status[bus_pkg::ST_TAKEN]               = slot_taken[head];
    head_status[bus_pkg::ST_FLAGS_LO +: 4]       = slot_flags[head];
    head_status[bus_pkg::ST_TAG_LO +: TAG_W]     = head;
  end

endmodule

// ==== design/alu_cluster.sv ====
// ####################################################################
// top level of the ALU cluster, a Wishbone slave feeding N_LANES
// identical lanes whose results retire in order through the collector
// ####################################################################
`timescale 1ns/100ps

module alu_cluster #(
  parameter int N_LANES   = 4,
  parameter int ROB_DEPTH = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  logic [bus_pkg::ADR_W-1:0] adr,
  input  logic [bus_pkg::BUS_W-1:0] dat_w,
  output logic [bus_pkg::BUS_W-1:0] dat_r,
  output logic                      ack
);

  localparam int TAG_W = $clog2(ROB_DEPTH);

  logic [N_LANES-1:0]                     issue;
  alu_pkg::cmd_t                          cmd;
  logic [bus_pkg::BUS_W-1:0]              opa;
  logic [bus_pkg::BUS_W-1:0]              opb;
  logic [TAG_W-1:0]                       tag;
  logic                                   pop;
  logic                                   head_valid;
  logic [bus_pkg::BUS_W-1:0]              head_result;
  logic [bus_pkg::BUS_W-1:0]              head_status;
  logic [N_LANES-1:0]                     lane_busy;
  logic [N_LANES-1:0]                     lane_done;
  logic [N_LANES-1:0]                     lane_taken;
  logic [N_LANES-1:0][bus_pkg::BUS_W-1:0] lane_result;
  logic [N_LANES-1:0][3:0]                lane_flags;
  logic [N_LANES-1:0][TAG_W-1:0]          lane_tag;

  op_dispatch #(
    .N_LANES   (N_LANES),
    .ROB_DEPTH (ROB_DEPTH)
  ) i_dispatch (
    .clk         (clk),
    .rst         (rst),
    .cyc         (cyc),
    .stb         (stb),
    .we          (we),
    .adr         (adr),
    .dat_w       (dat_w),
    .dat_r       (dat_r),
    .ack         (ack),
    .issue       (issue),
    .cmd         (cmd),
    .opa         (opa),
    .opb         (opb),
    .tag         (tag),
    .lane_busy   (lane_busy),
    .pop         (pop),
    .head_valid  (head_valid),
    .head_result (head_result),
    .head_status (head_status)
  );

  // shared command bus, per-lane strobes and returns
  for (genvar i = 0; i < N_LANES; i++) begin : g_lane
    exec_lane #(
      .ROB_DEPTH (ROB_DEPTH)
    ) i_lane (
      .clk        (clk),
      .rst        (rst),
      .issue      (issue[i]),
      .cmd        (cmd),
      .opa        (opa),
      .opb        (opb),
      .tag        (tag),
      .busy       (lane_busy[i]),
      .done       (lane_done[i]),
      .result     (lane_result[i]),
      .flags_out  (lane_flags[i]),
      .cond_taken (lane_taken[i]),
      .tag_out    (lane_tag[i])
    );
  end

  result_collector #(
    .N_LANES   (N_LANES),
    .ROB_DEPTH (ROB_DEPTH)
  ) i_collector (
    .clk         (clk),
    .rst         (rst),
    .lane_done   (lane_done),
    .lane_result (lane_result),
    .lane_flags  (lane_flags),
    .lane_taken  (lane_taken),
    .lane_tag    (lane_tag),
    .pop         (pop),
    .head_valid  (head_valid),
    .head_result (head_result),
    .head_status (head_status)
  );

endmodule

// ==== test/alu_cluster_sva.sv ====
// ####################################################################
// Wishbone protocol and retire order checks, bound into alu_cluster
// ####################################################################
`timescale 1ns/100ps

module alu_cluster_sva #(
  parameter int ROB_DEPTH = 8
) (
  input logic                      clk,
  input logic                      rst,
  input logic                      cyc,
  input logic                      stb,
  input logic                      we,
  input logic [bus_pkg::ADR_W-1:0] adr,
  input logic [bus_pkg::BUS_W-1:0] dat_r,
  input logic                      ack
);

  localparam int TAG_W = $clog2(ROB_DEPTH);

  logic             status_pop;
  logic [TAG_W-1:0] next_tag;

  assign status_pop = ack && !we && (adr == bus_pkg::ADR_STATUS) && dat_r[bus_pkg::ST_VALID];

  always_ff @(posedge clk) begin
    if (rst)             next_tag <= '0;
    else if (status_pop) next_tag <= next_tag + 1'b1;
  end

  ack_needs_req: assert property (@(posedge clk) disable iff (rst) ack |-> cyc && stb)
    else $error("ack raised without cyc and stb");

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else $error("ack held for two cycles");

  tag_in_order: assert property (@(posedge clk) disable iff (rst)
    status_pop |-> dat_r[bus_pkg::ST_TAG_LO +: TAG_W] == next_tag)
    else $error("status tag out of sequence");

endmodule

bind alu_cluster alu_cluster_sva #(.ROB_DEPTH(ROB_DEPTH)) i_sva (
  .clk   (clk),
  .rst   (rst),
  .cyc   (cyc),
  .stb   (stb),
  .we    (we),
  .adr   (adr),
  .dat_r (dat_r),
  .ack   (ack)
);

// ==== test/tb_alu_cluster.sv ====
// ####################################################################
// testbench for alu_cluster: drives the Wishbone port, models every
// operation in ref_exec and checks results as they retire in order
// ####################################################################
`timescale 1ns/100ps

module tb_alu_cluster;

  localparam int N_LANES   = 4;
  localparam int ROB_DEPTH = 8;
  localparam int TAG_W     = $clog2(ROB_DEPTH);
  localparam int SETTLE    = alu_pkg::MUL_LAT + 4;  // issue, lane pipe, collector write
  localparam int TIMEOUT   = 20000;

  typedef struct packed {
    logic [31:0]      res;
    logic [3:0]       flags;
    logic             taken;
    logic [TAG_W-1:0] tag;
    int               at;     // cycle the CMD ack was seen
  } exp_t;

  logic        clk;
  logic        rst = 1'b1;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [2:0]  adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;

  exp_t             exp_q[$];
  logic [TAG_W-1:0] next_tag = '0;
  logic             bus_lock = 1'b0;
  logic             chk_hold = 1'b0;
  int               cyc_cnt = 0;
  int               n_acked = 0;
  int               n_checked = 0;
  int               n_errors = 0;

  alu_cluster #(
    .N_LANES   (N_LANES),
    .ROB_DEPTH (ROB_DEPTH)
  ) i_dut (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

  task automatic check_val(input string name, input logic [31:0] expv, input logic [31:0] got);
    if (got !== expv) begin
      n_errors++;
      $display("MISMATCH %s expected 0x%08h got 0x%08h", name, expv, got);
      $display("sim failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  // one bus cycle; patience 0 waits for ack without limit
  task automatic bus_xfer(input logic wr, input logic [2:0] a, input logic [31:0] wd,
                          input int patience, output logic [31:0] rd, output logic ok);
    int waited;
    waited = 0;
    ok = 1'b0;
    rd = '0;
    while (bus_lock) @(negedge clk);
    bus_lock = 1'b1;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = a;
    dat_w = wd;
    while (!ok && (patience == 0 || waited < patience)) begin
      @(negedge clk);
      waited++;
      if (ack) begin
        ok = 1'b1;
        rd = dat_r;
      end
    end
    if (ok) @(negedge clk);  // hold through the ack edge
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    bus_lock = 1'b0;
  endtask

  function automatic logic [31:0] pack_cmd(logic [3:0] op, logic [3:0] cond, logic [3:0] fl,
                                           logic use_imm, logic [15:0] payload);
    return {op, cond, fl, use_imm, 3'b000, payload};
  endfunction

  function automatic logic [31:0] rand_word();
    case ($urandom_range(7, 0))
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff;
      2:       return 32'h8000_0000;
      3:       return 32'($urandom_range(31, 0));
      default: return $urandom;
    endcase
  endfunction

  // returns {taken, flags, result}
  function automatic logic [36:0] ref_exec(logic [31:0] a, logic [31:0] b_reg, logic [31:0] cw);
    logic [3:0]  op;
    logic [3:0]  fin;
    logic [31:0] b;
    logic [31:0] res;
    logic [32:0] wide;
    logic [63:0] prod;
    logic        base;
    logic        co;
    logic        ov;
    op   = cw[31:28];
    fin  = cw[23:20];
    b    = cw[19] ? {{16{cw[15]}}, cw[15:0]} : b_reg;
    prod = 64'(a) * 64'(b);
    co   = 1'b0;
    ov   = 1'b0;
    // odd codes negate the even code below them
    case (cw[27:25])
      3'd0:    base = fin[0];
      3'd1:    base = fin[3];
      3'd2:    base = fin[1];
      3'd3:    base = fin[2];
      3'd4:    base = fin[3] && !fin[0];
      3'd5:    base = fin[1] == fin[2];
      3'd6:    base = !fin[0] && (fin[1] == fin[2]);
      default: base = 1'b1;
    endcase
    if (!(base ^ cw[24])) return {1'b0, fin, a};
    case (op)
      alu_pkg::OP_ADD, alu_pkg::OP_ADC: begin
        wide = {1'b0, a} + {1'b0, b} + 33'(op == alu_pkg::OP_ADC && fin[3]);
        res  = wide[31:0];
        co   = wide[32];
        ov   = (a[31] == b[31]) && (res[31] != a[31]);
      end
      alu_pkg::OP_SUB: begin
        res = a - b;
        co  = a >= b;  // no borrow
        ov  = (a[31] != b[31]) && (res[31] != a[31]);
      end
      alu_pkg::OP_AND:   res = a & b;
      alu_pkg::OP_OR:    res = a | b;
      alu_pkg::OP_XOR:   res = a ^ b;
      alu_pkg::OP_SLL:   res = a << b[4:0];
      alu_pkg::OP_SRL:   res = a >> b[4:0];
      alu_pkg::OP_SRA:   res = $signed(a) >>> b[4:0];
      alu_pkg::OP_SXT: begin
        case (cw[1:0])
          2'd0:    res = {{24{a[7]}}, a[7:0]};
          2'd1:    res = {{16{a[15]}}, a[15:0]};
          2'd2:    for (int i = 0; i < 4; i++) res[8*i +: 8] = a[8*(3-i) +: 8];
          default: res = a;
        endcase
      end
      alu_pkg::OP_MOVI:  res = b;
      alu_pkg::OP_MUL:   res = prod[31:0];
      default:           res = prod[63:32];
    endcase
    return {1'b1, co, ov, res[31], res == 32'h0, res};
  endfunction

  task automatic run_op(input logic [31:0] a, input logic [31:0] b, input logic [31:0] cw);
    logic [31:0] rd;
    logic [36:0] ref_val;
    logic        ok;
    exp_t        e;
    bus_xfer(1'b1, bus_pkg::ADR_OPA, a, 0, rd, ok);
    bus_xfer(1'b1, bus_pkg::ADR_OPB, b, 0, rd, ok);
    ok = 1'b0;
    while (!ok) begin
      bus_xfer(1'b1, bus_pkg::ADR_CMD, cw, 16, rd, ok);
      if (!ok) repeat (2) @(negedge clk);  // stalled, let the checker read
    end
    ref_val = ref_exec(a, b, cw);
    e.res   = ref_val[31:0];
    e.flags = ref_val[35:32];
    e.taken = ref_val[36];
    e.tag   = next_tag;
    e.at    = cyc_cnt;
    exp_q.push_back(e);
    next_tag = TAG_W'((next_tag + 1) % ROB_DEPTH);
    n_acked++;
  endtask

  task automatic drain_results();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  initial begin : result_check
    logic [31:0] res_rd;
    logic [31:0] st_rd;
    logic        ok;
    exp_t        e;
    wait (rst === 1'b0);
    forever begin
      @(negedge clk);
      if (!chk_hold && exp_q.size() > 0 && cyc_cnt >= exp_q[0].at + SETTLE) begin
        e = exp_q[0];
        bus_xfer(1'b0, bus_pkg::ADR_RESULT, '0, 0, res_rd, ok);
        bus_xfer(1'b0, bus_pkg::ADR_STATUS, '0, 0, st_rd, ok);
        check_val("status.valid", 32'd1, 32'(st_rd[bus_pkg::ST_VALID]));
        check_val("status.tag", 32'(e.tag), 32'(st_rd[bus_pkg::ST_TAG_LO +: TAG_W]));
        check_val("status.taken", 32'(e.taken), 32'(st_rd[bus_pkg::ST_TAKEN]));
        check_val("status.flags", 32'(e.flags), 32'(st_rd[bus_pkg::ST_FLAGS_LO +: 4]));
        check_val("result", e.res, res_rd);
        void'(exp_q.pop_front());
        n_checked++;
      end
    end
  end

  initial begin : watchdog
    wait (cyc_cnt >= TIMEOUT);
    $display("timeout, the run did not finish within %0d cycles", TIMEOUT);
    $display("sim failed");
    $fatal(1, "run limit reached");
  end

  initial begin : stimulus
    logic [31:0] rd;
    logic        ok;
    logic [3:0]  op;
    int          base;
    void'($urandom(1075));
    rst   = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // empty collector reads valid 0 and pops nothing
    repeat (2) begin
      bus_xfer(1'b0, bus_pkg::ADR_STATUS, '0, 0, rd, ok);
      check_val("status.valid after reset", 32'd0, 32'(rd[bus_pkg::ST_VALID]));
    end

    repeat (200) run_op(rand_word(), rand_word(), pack_cmd(4'($urandom_range(12, 0)),
                        alu_pkg::COND_ALWAYS, 4'($urandom), 1'b0, 16'($urandom)));
    repeat (200) run_op(rand_word(), rand_word(), pack_cmd(4'($urandom_range(12, 0)),
                        4'($urandom), 4'($urandom), 1'b0, 16'($urandom)));

    // immediate view, then every sxt mode
    repeat (40) run_op(rand_word(), rand_word(), pack_cmd(4'($urandom_range(12, 0)),
                       alu_pkg::COND_ALWAYS, 4'($urandom), 1'b1, 16'($urandom)));
    for (int m = 0; m < 4; m++) begin
      repeat (8) run_op(rand_word(), rand_word(), pack_cmd(alu_pkg::OP_SXT,
                        alu_pkg::COND_ALWAYS, 4'($urandom), 1'b0, {14'($urandom), 2'(m)}));
    end

    // multiplies rotate over the lanes between short ops
    for (int i = 0; i < 60; i++) begin
      case (i % 3)
        0:       op = alu_pkg::OP_MUL;
        1:       op = alu_pkg::OP_MULHU;
        default: op = 4'($urandom_range(10, 0));
      endcase
      run_op(rand_word(), rand_word(),
             pack_cmd(op, alu_pkg::COND_ALWAYS, 4'($urandom), 1'b0, 16'($urandom)));
    end

    // overrun the reorder slots with the checker held off
    drain_results();
    chk_hold = 1'b1;
    base = n_acked;
    fork
      repeat (ROB_DEPTH + 3) run_op(rand_word(), rand_word(), pack_cmd(
                                    4'($urandom_range(12, 0)), alu_pkg::COND_ALWAYS,
                                    4'($urandom), 1'b0, 16'($urandom)));
      begin
        repeat (150) @(negedge clk);
        check_val("cmd acks while paused", 32'(ROB_DEPTH), 32'(n_acked - base));
        chk_hold = 1'b0;
      end
    join
    drain_results();

    bus_xfer(1'b0, bus_pkg::ADR_STATUS, '0, 0, rd, ok);
    check_val("status.valid when drained", 32'd0, 32'(rd[bus_pkg::ST_VALID]));
    check_val("results retired", 32'(n_acked), 32'(n_checked));
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
design/alu_pkg.sv
design/bus_pkg.sv
design/op_dispatch.sv
design/exec_lane.sv
design/result_collector.sv
design/alu_cluster.sv
test/alu_cluster_sva.sv
test/tb_alu_cluster.sv
